/* mul_cluster_top.f */
rtl/mul_pkg.sv
rtl/shift_add_mul.sv
rtl/mul_engine.sv
rtl/wb_arbiter.sv
rtl/wb_ram.sv
rtl/mul_cluster_top.sv
test/tb_mul_cluster.sv

/* Bender.yml */
package:
  name: mul_cluster

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - rtl/mul_pkg.sv
      - rtl/shift_add_mul.sv
      - rtl/mul_engine.sv
      - rtl/wb_arbiter.sv
      - rtl/wb_ram.sv
      - rtl/mul_cluster_top.sv
  - target: test
    files:
      - test/tb_mul_cluster.sv

/* test/tb_mul_cluster.sv */
`timescale 1ns/1ps
/* Random self-checking testbench for the multiply cluster, fixed seed.
   A word model mirrors every host write. Expected products are the unsigned
   64-bit product of the model operands. Memory regions per test are disjoint. */
module tb_mul_cluster import mul_pkg::*; ();

    localparam int MAX_CONC    = 12;                             // Longest concurrent job
    localparam int TOTAL_PAIRS = 10 + 4 + 2 * MAX_CONC + 5;
    localparam int TIMEOUT_CYC = TOTAL_PAIRS * (MUL_STEPS + 40) + 2000;

    logic               clk = 1'b0;
    logic               reset_n;
    logic               host_cyc, host_stb, host_we, host_ack;
    logic [ADDR_W-1:0]  host_adr;
    logic [DATA_W-1:0]  host_dat_w, host_dat_r;
    logic               start_0, start_1, busy_0, busy_1, done_0, done_1;
    logic [ADDR_W-1:0]  base_0, base_1;
    logic [PAIRS_W-1:0] pairs_0, pairs_1;

    logic [DATA_W-1:0] model [MEM_DEPTH];  // Expected memory contents
    logic [DATA_W-1:0] x_op;                // Shared operand for the corner pairs
    int                wr_adr [32];         // Addresses hit by the memory path test
    integer            seed = 32'hf2e8469e;
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;
    int                len0, len1;

    mul_cluster_top DUT (.*);

    always #20 clk = ~clk;  // 40 ns period

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("Timeout after %0d cycles, the run did not complete", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic check_value(input string name, input logic [PROD_W-1:0] exp,
                               input logic [PROD_W-1:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, exp, got);
        end
    endtask

    // One classic access, held until host_ack
    task automatic host_access(input bit wr, input int a, input logic [DATA_W-1:0] d,
                               output logic [DATA_W-1:0] q);
        @(posedge clk);
        host_cyc   <= 1'b1;
        host_stb   <= 1'b1;
        host_we    <= wr;
        host_adr   <= ADDR_W'(a);
        host_dat_w <= d;
        do begin
            @(negedge clk);  // Sample mid cycle
        end while (!host_ack);
        q = host_dat_r;
        @(posedge clk);     // Write lands on this edge
        host_cyc <= 1'b0;
        host_stb <= 1'b0;
        host_we  <= 1'b0;
    endtask

    task automatic host_write(input int a, input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] q;
        host_access(1'b1, a, d, q);
        model[ADDR_W'(a)] = d;
    endtask

    task automatic read_compare(input int a, input string name);
        logic [DATA_W-1:0] q;
        host_access(1'b0, a, '0, q);
        check_value(name, PROD_W'(model[ADDR_W'(a)]), PROD_W'(q));
    endtask

    task automatic load_pairs(input int base, input int n);
        for (int i = 0; i < n; i++) begin
            host_write(base + PAIR_WORDS * i + OFF_A, $random(seed));
            host_write(base + PAIR_WORDS * i + OFF_B, $random(seed));
        end
    endtask

    // Expected product from the model operands, then read both words back
    task automatic check_products(input int base, input int n, input string tag);
        logic [PROD_W-1:0] exp;
        int                r;
        for (int i = 0; i < n; i++) begin
            r   = base + PAIR_WORDS * i;
            exp = PROD_W'(model[ADDR_W'(r + OFF_A)]) * PROD_W'(model[ADDR_W'(r + OFF_B)]);
            model[ADDR_W'(r + OFF_LO)] = exp[DATA_W-1:0];
            model[ADDR_W'(r + OFF_HI)] = exp[PROD_W-1:DATA_W];
            read_compare(r + OFF_LO, $sformatf("%s pair %0d lo", tag, i));
            read_compare(r + OFF_HI, $sformatf("%s pair %0d hi", tag, i));
        end
    endtask

    task automatic start_job(input int eng, input int base, input int n);
        @(posedge clk);
        if (eng == 0) begin
            start_0 <= 1'b1;
            base_0  <= ADDR_W'(base);
            pairs_0 <= PAIRS_W'(n);
        end else begin
            start_1 <= 1'b1;
            base_1  <= ADDR_W'(base);
            pairs_1 <= PAIRS_W'(n);
        end
        @(posedge clk);
        start_0 <= 1'b0;  // Single-cycle pulse
        start_1 <= 1'b0;
    endtask

    task automatic wait_done(input int eng, input int n);
        int limit;
        int cnt;
        bit seen;
        limit = n * (MUL_STEPS + 40) + 200;  // Generous, bus contention included
        cnt   = 0;
        seen  = 1'b0;
        while (!seen && cnt < limit) begin
            @(negedge clk);
            cnt++;
            seen = (eng == 0) ? done_0 : done_1;
        end
        if (!seen) begin
            errors++;
            $display("Engine %0d gave no done pulse within %0d cycles", eng, limit);
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        reset_n    = 1'b0;
        host_cyc   = 1'b0;
        host_stb   = 1'b0;
        host_we    = 1'b0;
        host_adr   = '0;
        host_dat_w = '0;
        start_0    = 1'b0;
        start_1    = 1'b0;
        base_0     = '0;
        base_1     = '0;
        pairs_0    = '0;
        pairs_1    = '0;
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;

        // Reset state
        @(negedge clk);
        check_value("reset busy_0", 0, PROD_W'(busy_0));
        check_value("reset busy_1", 0, PROD_W'(busy_1));
        check_value("reset done_0", 0, PROD_W'(done_0));
        check_value("reset done_1", 0, PROD_W'(done_1));
        check_value("reset host_ack", 0, PROD_W'(host_ack));

        // Memory path, random addresses, read back after all writes
        for (int i = 0; i < 32; i++) begin
            wr_adr[i] = {$random(seed)} % MEM_DEPTH;
            host_write(wr_adr[i], $random(seed));
        end
        foreach (wr_adr[i])
            read_compare(wr_adr[i], $sformatf("memory word %0d", wr_adr[i]));

        // Single job on engine 0, records at 0..39
        load_pairs(0, 10);
        start_job(0, 0, 10);
        wait_done(0, 10);
        check_value("single busy_0", 0, PROD_W'(busy_0));
        check_products(0, 10, "single");

        // Corner operands at 64
        x_op = $random(seed);
        host_write(64, 32'h0);
        host_write(65, x_op);
        host_write(68, 32'h1);
        host_write(69, x_op);
        host_write(72, 32'hffff_ffff);
        host_write(73, 32'hffff_ffff);
        host_write(76, 32'hffff_ffff);
        host_write(77, 32'h1);
        start_job(0, 64, 4);
        wait_done(0, 4);
        check_products(64, 4, "corner");

        // ----------------------------------------
        // Concurrent jobs plus host traffic at 192
        // ----------------------------------------
        len0 = 1 + {$random(seed)} % MAX_CONC;
        len1 = 1 + {$random(seed)} % MAX_CONC;
        load_pairs(96, len0);
        load_pairs(144, len1);
        fork
            begin
                start_job(0, 96, len0);
                wait_done(0, len0);
            end
            begin
                start_job(1, 144, len1);
                @(negedge clk);
                check_value("concurrent busy_1 running", 1, PROD_W'(busy_1));
                wait_done(1, len1);
                check_value("concurrent busy_1 finished", 0, PROD_W'(busy_1));
            end
            begin
                for (int i = 0; i < 16; i++)
                    host_write(192 + i, $random(seed));
                for (int i = 0; i < 16; i++)
                    read_compare(192 + i, $sformatf("host word %0d", 192 + i));
            end
        join
        check_products(96, len0, "concurrent eng0");
        check_products(144, len1, "concurrent eng1");

        // Restart while busy, record 5 at 244 must stay as written
        load_pairs(224, 6);
        host_write(224 + 20 + OFF_LO, $random(seed));
        host_write(224 + 20 + OFF_HI, $random(seed));
        start_job(0, 224, 5);
        repeat (8) @(posedge clk);
        @(negedge clk);
        assert (busy_0) else begin
            errors++;
            $display("Engine 0 was not busy before the restart pulse");
        end
        start_job(0, 244, 1);  // Would rewrite record 5 if taken
        wait_done(0, 5);
        repeat (40) begin
            @(negedge clk);
            assert (!busy_0 && !done_0) else begin
                errors++;
                $display("Engine 0 ran a second job after an ignored start");
            end
        end
        check_products(224, 5, "restart");
        for (int w = 20; w < 24; w++)
            read_compare(224 + w, $sformatf("restart record 5 word %0d", w - 20));

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* rtl/mul_cluster_top.sv */
`timescale 1ns/1ps
/* Multiply cluster: host port plus two engines sharing one word memory.
   Host is arbiter slot 0, engines are slots 1 and 2. No fixed latency,
   a host access completes on host_ack. */
module mul_cluster_top import mul_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    // Host Wishbone port
    input  logic               host_cyc,
    input  logic               host_stb,
    input  logic               host_we,
    input  logic [ADDR_W-1:0]  host_adr,
    input  logic [DATA_W-1:0]  host_dat_w,
    output logic [DATA_W-1:0]  host_dat_r,
    output logic               host_ack,
    // Engine 0 job control
    input  logic               start_0,
    input  logic [ADDR_W-1:0]  base_0,
    input  logic [PAIRS_W-1:0] pairs_0,
    output logic               busy_0,
    output logic               done_0,
    // Engine 1 job control
    input  logic               start_1,
    input  logic [ADDR_W-1:0]  base_1,
    input  logic [PAIRS_W-1:0] pairs_1,
    output logic               busy_1,
    output logic               done_1
);

    // ----------------------------------------
    // Master side buses
    // ----------------------------------------
    logic [N_MASTERS-1:0]             m_cyc;
    logic [N_MASTERS-1:0]             m_stb;
    logic [N_MASTERS-1:0]             m_we;
    logic [N_MASTERS-1:0][ADDR_W-1:0] m_adr;
    logic [N_MASTERS-1:0][DATA_W-1:0] m_dat_w;
    logic [N_MASTERS-1:0]             m_ack;
    logic [DATA_W-1:0]                dat_r;   // Broadcast read data

    // Slave side
    logic              s_cyc, s_stb, s_we, s_ack;
    logic [ADDR_W-1:0] s_adr;
    logic [DATA_W-1:0] s_dat_w;

    // Host on slot 0
    assign m_cyc[0]   = host_cyc;
    assign m_stb[0]   = host_stb;
    assign m_we[0]    = host_we;
    assign m_adr[0]   = host_adr;
    assign m_dat_w[0] = host_dat_w;
    assign host_ack   = m_ack[0];
    assign host_dat_r = dat_r;

    mul_engine u_eng0 (
        .clk (clk), .reset_n (reset_n),
        .start (start_0), .base (base_0), .pairs (pairs_0),
        .busy (busy_0), .done (done_0),
        .cyc (m_cyc[1]), .stb (m_stb[1]), .we (m_we[1]),
        .adr (m_adr[1]), .dat_w (m_dat_w[1]),
        .dat_r (dat_r), .ack (m_ack[1])
    );

    mul_engine u_eng1 (
        .clk (clk), .reset_n (reset_n),
        .start (start_1), .base (base_1), .pairs (pairs_1),
        .busy (busy_1), .done (done_1),
        .cyc (m_cyc[2]), .stb (m_stb[2]), .we (m_we[2]),
        .adr (m_adr[2]), .dat_w (m_dat_w[2]),
        .dat_r (dat_r), .ack (m_ack[2])
    );

    wb_arbiter u_arb (
        .clk (clk), .reset_n (reset_n),
        .m_cyc (m_cyc), .m_stb (m_stb), .m_we (m_we),
        .m_adr (m_adr), .m_dat_w (m_dat_w), .m_ack (m_ack),
        .s_cyc (s_cyc), .s_stb (s_stb), .s_we (s_we),
        .s_adr (s_adr), .s_dat_w (s_dat_w), .s_ack (s_ack)
    );

    wb_ram u_ram (
        .clk (clk), .reset_n (reset_n),
        .cyc (s_cyc), .stb (s_stb), .we (s_we),
        .adr (s_adr), .dat_w (s_dat_w),
        .dat_r (dat_r), .ack (s_ack)
    );

endmodule

/* rtl/wb_ram.sv */
`timescale 1ns/1ps
/* Wishbone classic single-port word memory, MEM_DEPTH words, no byte selects.
   ack comes one cycle after cyc and stb, never two cycles in a row.
   Contents are undefined after power-up; reset clears only the ack. */
module wb_ram import mul_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [ADDR_W-1:0] adr,
    input  logic [DATA_W-1:0] dat_w,
    output logic [DATA_W-1:0] dat_r,
    output logic              ack
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic              sel;

    assign sel = cyc && stb;

    // Ack lasts one cycle; the gap lets the master drop cyc
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            ack <= 1'b0;
        else
            ack <= sel && !ack;
    end

    always_ff @(posedge clk) begin
        if (sel && we && ack)
            mem[adr] <= dat_w;  // Write lands on the ack edge
        dat_r <= mem[adr];      // Valid together with ack
    end

endmodule

/* rtl/wb_arbiter.sv */
`timescale 1ns/1ps
/* Round-robin arbiter for N_MASTERS Wishbone classic masters, one slave.
   A grant is held while the granted cyc stays high. Handing the bus to a
   new master costs one cycle in which nothing reaches the slave. */
module wb_arbiter import mul_pkg::*; (
    input  logic                              clk,
    input  logic                              reset_n,
    input  logic [N_MASTERS-1:0]              m_cyc,
    input  logic [N_MASTERS-1:0]              m_stb,
    input  logic [N_MASTERS-1:0]              m_we,
    input  logic [N_MASTERS-1:0][ADDR_W-1:0]  m_adr,
    input  logic [N_MASTERS-1:0][DATA_W-1:0]  m_dat_w,
    output logic [N_MASTERS-1:0]              m_ack,
    output logic                              s_cyc,
    output logic                              s_stb,
    output logic                              s_we,
    output logic [ADDR_W-1:0]                 s_adr,
    output logic [DATA_W-1:0]                 s_dat_w,
    input  logic                              s_ack
);

    logic [GRANT_W-1:0]   gnt;        // Current, or last, granted master
    logic                 gnt_valid;
    logic [GRANT_W-1:0]   nxt;        // Next winner after gnt
    logic [N_MASTERS-1:0] req;
    logic                 bus_free;

    assign req      = m_cyc & m_stb;
    assign bus_free = !gnt_valid || !m_cyc[gnt];  // Owner gone or never there

    // ----------------------------------------
    // Round-robin pick
    // ----------------------------------------
    // Walk from the farthest slot back, so the closest requester after gnt wins
    always_comb begin
        int cand;
        nxt = gnt;
        for (int i = N_MASTERS; i >= 1; i--) begin
            cand = (int'(gnt) + i) % N_MASTERS;
            if (req[cand])
                nxt = GRANT_W'(cand);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            gnt       <= '0;
            gnt_valid <= 1'b0;
        end else if (bus_free) begin
            gnt_valid <= |req;
            if (|req)
                gnt <= nxt;  // Takes effect next cycle
        end
    end

    // ----------------------------------------
    // Routing
    // ----------------------------------------
    assign s_cyc   = gnt_valid && m_cyc[gnt];
    assign s_stb   = gnt_valid && m_stb[gnt];
    assign s_we    = m_we[gnt];
    assign s_adr   = m_adr[gnt];
    assign s_dat_w = m_dat_w[gnt];

    always_comb begin
        for (int i = 0; i < N_MASTERS; i++)
            m_ack[i] = s_ack && gnt_valid && (gnt == GRANT_W'(i));  // Owner only
    end

endmodule

/* rtl/mul_engine.sv */
`timescale 1ns/1ps
/* Wishbone classic master that multiplies a job of operand pairs in memory.
   Record i sits at base + PAIR_WORDS*i, addresses wrap at the memory top.
   start is ignored while busy. A zero pair count gives done at once.
   Each access is its own cyc, with one idle cycle between accesses. */
module mul_engine import mul_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    // Job control
    input  logic               start,
    input  logic [ADDR_W-1:0]  base,
    input  logic [PAIRS_W-1:0] pairs,
    output logic               busy,
    output logic               done,
    // Wishbone master
    output logic               cyc,
    output logic               stb,
    output logic               we,
    output logic [ADDR_W-1:0]  adr,
    output logic [DATA_W-1:0]  dat_w,
    input  logic [DATA_W-1:0]  dat_r,
    input  logic               ack
);

    eng_state_t         state;
    logic [PAIRS_W-1:0] pairs_q;    // Job length
    logic [PAIRS_W-1:0] pair_idx;   // Pair in progress
    logic [ADDR_W-1:0]  rec_adr;    // Record base for pair_idx
    logic [ADDR_W-1:0]  adr_off;    // Word within the record
    logic               cyc_q;
    logic [DATA_W-1:0]  op_a;
    logic [DATA_W-1:0]  op_b;
    logic [PROD_W-1:0]  prod;
    logic               mul_start;  // Held until the core takes it
    logic               mul_ready;
    logic               mul_done;
    logic [PROD_W-1:0]  mul_product;

    shift_add_mul u_mul (
        .clk     (clk),
        .reset_n (reset_n),
        .start   (mul_start),
        .a       (op_a),
        .b       (op_b),
        .ready   (mul_ready),
        .done    (mul_done),
        .product (mul_product)
    );

    // ----------------------------------------
    // Bus outputs
    // ----------------------------------------
    always_comb begin
        case (state)
            ENG_RD_B:  adr_off = ADDR_W'(OFF_B);
            ENG_WR_LO: adr_off = ADDR_W'(OFF_LO);
            ENG_WR_HI: adr_off = ADDR_W'(OFF_HI);
            default:   adr_off = ADDR_W'(OFF_A);
        endcase
    end

    assign cyc   = cyc_q;
    assign stb   = cyc_q;   // Classic, no wait states from the master
    assign we    = (state == ENG_WR_LO) || (state == ENG_WR_HI);
    assign adr   = rec_adr + adr_off;
    assign dat_w = (state == ENG_WR_HI) ? prod[PROD_W-1:DATA_W] : prod[DATA_W-1:0];
    assign busy  = (state != ENG_IDLE) && (state != ENG_DONE);
    assign done  = (state == ENG_DONE);  // Single cycle, DONE never repeats itself

    // ----------------------------------------
    // Sequence
    // ----------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= ENG_IDLE;
            cyc_q     <= 1'b0;
            mul_start <= 1'b0;
            pairs_q   <= '0;
            pair_idx  <= '0;
            rec_adr   <= '0;
        end else begin
            if (mul_start && mul_ready)
                mul_start <= 1'b0;  // Core accepted
            case (state)
                ENG_IDLE, ENG_DONE: begin
                    state <= ENG_IDLE;
                    if (start) begin
                        pairs_q  <= pairs;
                        pair_idx <= '0;
                        rec_adr  <= base;
                        state    <= (pairs == '0) ? ENG_DONE : ENG_RD_A;
                    end
                end
                ENG_RD_A, ENG_RD_B, ENG_WR_LO, ENG_WR_HI: begin
                    if (!cyc_q) begin
                        cyc_q <= 1'b1;  // Open the access
                    end else if (ack) begin
                        cyc_q <= 1'b0;  // Close right after ack
                        case (state)
                            ENG_RD_A:  state <= ENG_RD_B;
                            ENG_RD_B: begin
                                state     <= ENG_MUL;
                                mul_start <= 1'b1;
                            end
                            ENG_WR_LO: state <= ENG_WR_HI;
                            default: begin  // High word written, pair complete
                                if (pair_idx == pairs_q - 1'b1) begin
                                    state <= ENG_DONE;
                                end else begin
                                    pair_idx <= pair_idx + 1'b1;
                                    rec_adr  <= rec_adr + ADDR_W'(PAIR_WORDS);
                                    state    <= ENG_RD_A;
                                end
                            end
                        endcase
                    end
                end
                ENG_MUL: if (mul_done) state <= ENG_WR_LO;
                default: state <= ENG_IDLE;
            endcase
        end
    end

    // Operand and product capture
    always_ff @(posedge clk) begin
        if (state == ENG_RD_A && cyc_q && ack)
            op_a <= dat_r;
        if (state == ENG_RD_B && cyc_q && ack)
            op_b <= dat_r;
        if (state == ENG_MUL && mul_done)
            prod <= mul_product;
    end

endmodule

/* rtl/shift_add_mul.sv */
`timescale 1ns/1ps
/* Unsigned 32x32 shift-add multiplier, one multiplier bit per clock.
   done comes MUL_STEPS+1 cycles after the accepting edge, and product
   holds until the next accepted start. There is no signed mode. */
module shift_add_mul import mul_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              start,    // Taken only while ready
    input  logic [DATA_W-1:0] a,        // Multiplicand
    input  logic [DATA_W-1:0] b,        // Multiplier
    output logic              ready,    // Core idle
    output logic              done,     // One-cycle result strobe
    output logic [PROD_W-1:0] product
);

    mul_state_t        state;
    logic [STEP_W-1:0] count;   // Steps still to run
    logic [PROD_W-1:0] mcand;   // Multiplicand, moves left each step
    logic [DATA_W-1:0] mplier;  // Multiplier, moves right each step
    logic [PROD_W-1:0] acc;     // Partial product
    logic [PROD_W-1:0] addend;
    logic              accept;

    assign ready   = (state == MUL_IDLE);
    assign accept  = start && ready;
    assign addend  = mplier[0] ? mcand : '0;  // Add only for a set multiplier bit
    assign product = acc;

    // ----------------------------------------
    // Control
    // ----------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= MUL_IDLE;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;  // Default, strobe only
            case (state)
                MUL_IDLE: begin
                    if (accept) begin
                        state <= MUL_RUN;
                        count <= STEP_W'(MUL_STEPS);
                    end
                end
                MUL_RUN: begin
                    if (count == '0) begin  // All bits consumed
                        state <= MUL_IDLE;
                        done  <= 1'b1;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= MUL_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            mcand  <= PROD_W'(a);
            mplier <= b;
            acc    <= '0;  // Fresh product
        end else if (state == MUL_RUN && count != '0) begin
            acc    <= acc + addend;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

/* rtl/mul_pkg.sv */
/* Shared widths, memory layout and state encodings for the multiply cluster.
   Addresses are word addresses. Master 0 is the host, 1 and 2 the engines.
   A job record is four words: a, b, product low, product high. */
package mul_pkg;

    // ----------------------------------------
    // Widths and sizes
    // ----------------------------------------
    localparam int DATA_W    = 32;                     // Bus and operand width
    localparam int PROD_W    = 64;                     // Full unsigned product
    localparam int ADDR_W    = 8;                      // Word address
    localparam int MEM_DEPTH = 256;                    // 2**ADDR_W words
    localparam int N_MASTERS = 3;                      // Host plus two engines
    localparam int GRANT_W   = $clog2(N_MASTERS);      // Grant index width
    localparam int MUL_STEPS = 32;                     // One step per multiplier bit
    localparam int STEP_W    = $clog2(MUL_STEPS + 1);  // Holds MUL_STEPS down to 0
    localparam int PAIRS_W   = 6;                      // Up to 63 pairs per job

    // ----------------------------------------
    // Job record layout
    // ----------------------------------------
    localparam int PAIR_WORDS = 4;  // Record stride
    localparam int OFF_A      = 0;  // Operand a
    localparam int OFF_B      = 1;  // Operand b
    localparam int OFF_LO     = 2;  // Product bits 31:0
    localparam int OFF_HI     = 3;  // Product bits 63:32

    // Multiplier core
    typedef enum logic {
        MUL_IDLE,
        MUL_RUN
    } mul_state_t;

    // Engine sequence, one pass per pair
    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_RD_A,
        ENG_RD_B,
        ENG_MUL,
        ENG_WR_LO,
        ENG_WR_HI,
        ENG_DONE
    } eng_state_t;

endpackage
